// File: verilog.f
+incdir+tb
hw/jtag_pkg.sv
hw/tapnw_pkg.sv
hw/tap_fsm.sv
hw/tap_shift_reg.sv
hw/mtap.sv
hw/stap.sv
hw/tapnw_chain_router.sv
hw/tapnw_top.sv
tb/tb_tapnw_top.sv

// File: tb/tb_jtag_tasks.svh
//----------------------------------------------------------------------
// JTAG driving tasks, LFSR stimulus and the expected-value model.
// Included inside the testbench top after its signal declarations.
//----------------------------------------------------------------------

`ifndef TB_JTAG_TASKS_SVH
`define TB_JTAG_TASKS_SVH

//----------------------------------------------------------------------
// Pin level driving
//----------------------------------------------------------------------
// One tck cycle: drive on the rising edge, sample tdo at the falling one
task automatic jtag_step(input logic tms_v, input logic tdi_v, input logic shifting,
                         output logic tdo_v);
    @(posedge tck);
    tms            <= tms_v;
    tdi            <= tdi_v;
    shift_expected <= shifting;
    @(negedge tck);
    tdo_v = tdo;
endtask

// Five tms-high edges, then one low edge toward Run-Test/Idle
task automatic goto_reset();
    logic unused_tdo;
    repeat (GOTO_STEPS - 1) begin
        jtag_step(1'b1, 1'b0, 1'b0, unused_tdo);
    end
    jtag_step(1'b0, 1'b0, 1'b0, unused_tdo);
endtask

// IR or DR scan from Run-Test/Idle back to Run-Test/Idle
// tx_bits go in LSB first, rx_bits collect tdo
task automatic scan(input logic is_ir, input int len);
    logic unused_tdo;
    jtag_step(1'b1, 1'b0, 1'b0, unused_tdo);
    if (is_ir) begin
        jtag_step(1'b1, 1'b0, 1'b0, unused_tdo);
    end
    // Capture, then into Shift
    jtag_step(1'b0, 1'b0, 1'b0, unused_tdo);
    jtag_step(1'b0, 1'b0, 1'b0, unused_tdo);
    for (int k = 0; k < len; k++) begin
        jtag_step(k == len - 1, tx_bits[k], 1'b1, rx_bits[k]);
    end
    // Exit1, Update, Run-Test/Idle with the update applied
    jtag_step(1'b1, 1'b0, 1'b0, unused_tdo);
    jtag_step(1'b0, 1'b0, 1'b0, unused_tdo);
    jtag_step(1'b0, 1'b0, 1'b0, unused_tdo);
endtask

//----------------------------------------------------------------------
// Random bits
//----------------------------------------------------------------------
// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic rand_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        value[i]   = lfsr_state[0];
    end
endtask

//----------------------------------------------------------------------
// Expected-value model
//----------------------------------------------------------------------
// Master is tap -1
function automatic logic [31:0] exp_idcode(input int tap);
    case (tap)
        0:       return 32'h1111_1111;
        1:       return 32'h2222_2223;
        2:       return 32'h3333_3333;
        3:       return 32'h4444_4445;
        default: return 32'h1234_5679;
    endcase
endfunction

// Master plus enabled slaves
function automatic int active_taps(input enable_mask_t mask);
    int count;
    count = 1;
    for (int i = 0; i < NUM_STAPS; i++) begin
        count += mask[i];
    end
    return count;
endfunction

// Every active TAP captures the same opcode
task automatic fill_ir_expect(input int len, input ir_t opcode);
    for (int k = 0; k < len; k++) begin
        exp_bits[k] = opcode[k % IR_WIDTH];
    end
endtask

task automatic build_idcode_expect(input enable_mask_t mask, output int len);
    logic [31:0] code;
    len = 0;
    // Element nearest tdo first: highest enabled slave, master last
    for (int tap = NUM_STAPS - 1; tap >= -1; tap--) begin
        if (tap < 0 || mask[tap]) begin
            code = exp_idcode(tap);
            for (int b = 0; b < IDCODE_WIDTH; b++) begin
                exp_bits[len + b] = code[b];
            end
            len += IDCODE_WIDTH;
        end
    end
endtask

`endif

// File: tb/tb_tapnw_top.sv
//----------------------------------------------------------------------
// Testbench for the TAP network: IDCODE readout, mask programming,
// chain order, bypass delay and IR capture over several LFSR masks.
//----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_tapnw_top
    import jtag_pkg::*;
    import tapnw_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_ROUNDS   = 3;
    localparam int BYP_DATA     = 16;
    localparam int MAX_BITS     = 256;
    localparam int GOTO_STEPS   = 6;
    // Worst-case entry plus exit steps of one scan
    localparam int SHIFT_OVH    = 7;
    localparam int IR_MAX       = IR_WIDTH * (NUM_STAPS + 1);
    localparam int ID_MAX       = IDCODE_WIDTH * (NUM_STAPS + 1);
    localparam int ROUND_STEPS  = 2 * GOTO_STEPS + 6 * SHIFT_OVH + 3 * IR_MAX
                                + (IR_WIDTH + NUM_STAPS) + ID_MAX + (BYP_DATA + NUM_STAPS + 1);
    localparam int TOTAL_STEPS  = RESET_CYCLES + 1 + GOTO_STEPS + SHIFT_OVH + IDCODE_WIDTH
                                + NUM_ROUNDS * ROUND_STEPS;
    localparam int WATCHDOG_CYCLES = 2 * TOTAL_STEPS + 50;

    logic         tck;
    logic         rst_n;
    logic         tms;
    logic         tdi;
    logic         tdo;
    logic         tdo_en;
    enable_mask_t enabletap;

    // Set with the stimulus, high while the TAPs should be in a Shift state
    logic         shift_expected;
    logic [31:0]  lfsr_state;
    enable_mask_t cur_mask;
    logic         tx_bits  [MAX_BITS];
    logic         rx_bits  [MAX_BITS];
    logic         exp_bits [MAX_BITS];
    int           errors;
    int           checks;
    int           tests;

    `include "tb_jtag_tasks.svh"

    tapnw_top tapnw_top_inst (
        .tck       (tck),
        .rst_n     (rst_n),
        .tms       (tms),
        .tdi       (tdi),
        .tdo       (tdo),
        .tdo_en    (tdo_en),
        .enabletap (enabletap)
    );

    always #(CLK_PERIOD / 2) tck = ~tck;

    //----------------------------------------------------------------------
    // Checkers
    //----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %0t: %s got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic compare_rx(input int len);
        for (int k = 0; k < len; k++) begin
            check_value($sformatf("tdo[%0d]", k), rx_bits[k], exp_bits[k]);
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests++;
        $display("done %-24s %0d errors", name, errors - err_start);
    endtask

    // tdo_en follows the Shift-IR/Shift-DR window
    assert property (@(posedge tck) disable iff (!rst_n) tdo_en == shift_expected)
        else begin
            errors++;
            $display("Fail %0t: tdo_en got %b, expected %b", $time,
                     $sampled(tdo_en), $sampled(shift_expected));
        end

    // Outputs idle when reset releases
    assert property (@(posedge tck) $rose(rst_n) |-> (!tdo_en && enabletap == '0))
        else begin
            errors++;
            $display("Fail %0t: tdo_en/enabletap not idle after reset", $time);
        end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, sequence did not finish",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    //----------------------------------------------------------------------
    // Stimulus sequence
    //----------------------------------------------------------------------
    initial begin
        int           err_start;
        int           n;
        int           len;
        logic [31:0]  rnd;
        logic [31:0]  code;
        enable_mask_t new_mask;
        tck            = 1'b0;
        rst_n          = 1'b0;
        tms            = 1'b1;
        tdi            = 1'b0;
        shift_expected = 1'b0;
        lfsr_state     = 32'ha5dc_532a;
        cur_mask       = '0;
        errors         = 0;
        checks         = 0;
        tests          = 0;

        repeat (RESET_CYCLES) @(posedge tck);
        rst_n <= 1'b1;
        @(negedge tck);
        err_start = errors;
        check_value("tdo_en", tdo_en, 0);
        check_value("enabletap", enabletap, 0);
        finish_test("reset state", err_start);

        // Master alone, IDCODE selected since reset
        err_start = errors;
        goto_reset();
        code = exp_idcode(-1);
        for (int k = 0; k < IDCODE_WIDTH; k++) begin
            tx_bits[k]  = 1'b0;
            exp_bits[k] = code[k];
        end
        scan(1'b0, IDCODE_WIDTH);
        compare_rx(IDCODE_WIDTH);
        finish_test("master idcode", err_start);

        for (int r = 0; r < NUM_ROUNDS; r++) begin
            // Slaves get BYPASS, master the select opcode in the last group
            err_start = errors;
            rand_bits(NUM_STAPS, rnd);
            new_mask = rnd[NUM_STAPS-1:0];
            n = active_taps(cur_mask);
            goto_reset();
            for (int k = 0; k < IR_WIDTH * n; k++) begin
                if (k < IR_WIDTH * (n - 1)) begin
                    tx_bits[k] = 1'b1;
                end else begin
                    tx_bits[k] = INSTR_TAPNW_SEL[k - IR_WIDTH * (n - 1)];
                end
            end
            scan(1'b1, IR_WIDTH * n);
            fill_ir_expect(IR_WIDTH * n, INSTR_IDCODE);
            compare_rx(IR_WIDTH * n);
            // Slave bypass bits ahead of the captured old mask
            len = (n - 1) + NUM_STAPS;
            for (int k = 0; k < len; k++) begin
                tx_bits[k]  = (k < n - 1) ? 1'b0 : new_mask[k - (n - 1)];
                exp_bits[k] = (k < n - 1) ? 1'b0 : cur_mask[k - (n - 1)];
            end
            scan(1'b0, len);
            compare_rx(len);
            check_value("enabletap", enabletap, new_mask);
            cur_mask = new_mask;
            finish_test($sformatf("mask programming r%0d", r), err_start);

            err_start = errors;
            goto_reset();
            build_idcode_expect(cur_mask, len);
            for (int k = 0; k < len; k++) begin
                tx_bits[k] = 1'b0;
            end
            scan(1'b0, len);
            compare_rx(len);
            finish_test($sformatf("idcode chain r%0d", r), err_start);

            // All ones loads BYPASS everywhere
            err_start = errors;
            n = active_taps(cur_mask);
            for (int k = 0; k < IR_WIDTH * n; k++) begin
                tx_bits[k] = 1'b1;
            end
            scan(1'b1, IR_WIDTH * n);
            fill_ir_expect(IR_WIDTH * n, INSTR_IDCODE);
            compare_rx(IR_WIDTH * n);
            rand_bits(BYP_DATA, rnd);
            len = BYP_DATA + n;
            for (int k = 0; k < len; k++) begin
                tx_bits[k]  = (k < BYP_DATA) ? rnd[k] : 1'b0;
                exp_bits[k] = (k < n) ? 1'b0 : tx_bits[k - n];
            end
            scan(1'b0, len);
            compare_rx(len);
            finish_test($sformatf("bypass delay r%0d", r), err_start);

            err_start = errors;
            scan(1'b1, IR_WIDTH * n);
            fill_ir_expect(IR_WIDTH * n, INSTR_BYPASS);
            compare_rx(IR_WIDTH * n);
            finish_test($sformatf("ir capture r%0d", r), err_start);
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hw/tapnw_top.sv
//----------------------------------------------------------------------
// TAP network top: master TAP, four slave TAPs and the chain router
// behind one JTAG port. enabletap is brought out for observation.
//----------------------------------------------------------------------

`timescale 1ns/1ps

module tapnw_top
    import tapnw_pkg::*;
(
    input  logic         tck,
    input  logic         rst_n,
    input  logic         tms,
    input  logic         tdi,
    output logic         tdo,
    output logic         tdo_en,
    output enable_mask_t enabletap
);

    logic         mtap_tdo;
    enable_mask_t stap_tms;
    enable_mask_t stap_tdi;
    enable_mask_t stap_tdo;

    // Master sits directly on the external port
    mtap mtap_inst (
        .tck       (tck),
        .rst_n     (rst_n),
        .tms       (tms),
        .tdi       (tdi),
        .mtap_tdo  (mtap_tdo),
        .tdo_en    (tdo_en),
        .enabletap (enabletap),
        .stap_tms  (stap_tms)
    );

    // Slaves, tms gated by the master
    for (genvar i = 0; i < NUM_STAPS; i++) begin : g_stap
        stap #(
            .STAP_INDEX (i)
        ) stap_inst (
            .tck   (tck),
            .rst_n (rst_n),
            .tms   (stap_tms[i]),
            .tdi   (stap_tdi[i]),
            .tdo   (stap_tdo[i])
        );
    end

    tapnw_chain_router router_inst (
        .enabletap (enabletap),
        .mtap_tdo  (mtap_tdo),
        .stap_tdo  (stap_tdo),
        .stap_tdi  (stap_tdi),
        .tdo       (tdo)
    );

endmodule

// File: hw/tapnw_chain_router.sv
//----------------------------------------------------------------------
// Serial path of the TAP network: master first, then enabled slaves
// in ascending index. Disabled slaves are skipped with no delay.
//----------------------------------------------------------------------

`timescale 1ns/1ps

module tapnw_chain_router
    import tapnw_pkg::*;
(
    input  enable_mask_t enabletap,
    input  logic         mtap_tdo,
    input  enable_mask_t stap_tdo,
    output enable_mask_t stap_tdi,
    output logic         tdo
);

    //----------------------------------------------------------------------
    // Walk the chain from the master upward
    //----------------------------------------------------------------------
    // Slave tdo comes straight from registers, so no comb loop
    always_comb begin : chain_walk
        logic chain_bit;
        // Master acts as element -1
        chain_bit = mtap_tdo;
        for (int i = 0; i < NUM_STAPS; i++) begin
            // Nearest enabled element below feeds this slave
            stap_tdi[i] = chain_bit;
            if (enabletap[i]) begin
                chain_bit = stap_tdo[i];
            end
        end
        // Last enabled element, or the master alone
        tdo = chain_bit;
    end

    // Empty mask leaves only the master on the path
    always_comb begin
        if (enabletap == '0) begin
            assert final (tdo == mtap_tdo)
                else $error("tdo not from master with no slave enabled");
        end
    end

endmodule

// File: hw/stap.sv
//----------------------------------------------------------------------
// Slave TAP with IDCODE and BYPASS. STAP_INDEX picks its IDCODE
// from the network table; replicated in a generate loop at the top.
//----------------------------------------------------------------------

`timescale 1ns/1ps

module stap
    import jtag_pkg::*;
    import tapnw_pkg::*;
#(
    parameter int STAP_INDEX = 0
) (
    input  logic tck,
    input  logic rst_n,
    input  logic tms,
    input  logic tdi,
    output logic tdo
);

    tap_state_t state;
    logic       capture_dr;
    logic       shift_dr;
    logic       capture_ir;
    logic       shift_ir;
    logic       update_ir;

    ir_t  instr;
    logic ir_tdo;
    logic ir_rst_n;
    logic sel_idcode;

    logic [IDCODE_WIDTH-1:0] idcode_q;
    logic                    bypass_q;

    tap_fsm fsm_inst (
        .tck        (tck),
        .rst_n      (rst_n),
        .tms        (tms),
        .state      (state),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir)
    );

    // Parked slaves sit here with IDCODE selected
    assign ir_rst_n = rst_n && (state != ST_TLR);

    tap_shift_reg #(
        .payload_t   (ir_t),
        .RESET_VALUE (INSTR_IDCODE)
    ) ir_reg_inst (
        .tck     (tck),
        .rst_n   (ir_rst_n),
        .capture (capture_ir),
        .shift   (shift_ir),
        .update  (update_ir),
        .tdi     (tdi),
        .tdo     (ir_tdo),
        .value   (instr)
    );

    // No network select here, so only IDCODE or bypass
    assign sel_idcode = (instr == INSTR_IDCODE);

    always_ff @(posedge tck) begin
        if (!rst_n) begin
            idcode_q <= STAP_IDCODE[STAP_INDEX];
            bypass_q <= 1'b0;
        end else begin
            if (capture_dr && sel_idcode) begin
                idcode_q <= STAP_IDCODE[STAP_INDEX];
            end else if (shift_dr && sel_idcode) begin
                idcode_q <= {tdi, idcode_q[IDCODE_WIDTH-1:1]};
            end
            if (capture_dr) begin
                bypass_q <= 1'b0;
            end else if (shift_dr) begin
                bypass_q <= tdi;
            end
        end
    end

    assign tdo = shift_ir   ? ir_tdo      :
                 sel_idcode ? idcode_q[0] : bypass_q;

    // One edge in reset leaves IDCODE selected
    assert property (@(posedge tck) disable iff (!rst_n)
        (state == ST_TLR) |=> (instr == INSTR_IDCODE))
        else $error("slave %0d instruction not IDCODE in reset", STAP_INDEX);

endmodule

// File: hw/mtap.sv
//----------------------------------------------------------------------
// Master TAP: IDCODE, BYPASS and the network select register.
// Drives the slave enable mask and parks disabled slaves via tms.
//----------------------------------------------------------------------

`timescale 1ns/1ps

module mtap
    import jtag_pkg::*;
    import tapnw_pkg::*;
(
    input  logic         tck,
    input  logic         rst_n,
    input  logic         tms,
    input  logic         tdi,
    output logic         mtap_tdo,
    output logic         tdo_en,
    output enable_mask_t enabletap,
    output enable_mask_t stap_tms
);

    tap_state_t state;
    logic       capture_dr;
    logic       shift_dr;
    logic       update_dr;
    logic       capture_ir;
    logic       shift_ir;
    logic       update_ir;

    ir_t  instr;
    logic ir_tdo;
    logic ir_rst_n;

    logic sel_idcode;
    logic sel_nw;
    logic nw_tdo;

    logic [IDCODE_WIDTH-1:0] idcode_q;
    logic                    bypass_q;

    //----------------------------------------------------------------------
    // Controller and instruction register
    //----------------------------------------------------------------------
    tap_fsm fsm_inst (
        .tck        (tck),
        .rst_n      (rst_n),
        .tms        (tms),
        .state      (state),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir)
    );

    // Test-Logic-Reset returns the instruction to IDCODE
    assign ir_rst_n = rst_n && (state != ST_TLR);

    tap_shift_reg #(
        .payload_t   (ir_t),
        .RESET_VALUE (INSTR_IDCODE)
    ) ir_reg_inst (
        .tck     (tck),
        .rst_n   (ir_rst_n),
        .capture (capture_ir),
        .shift   (shift_ir),
        .update  (update_ir),
        .tdi     (tdi),
        .tdo     (ir_tdo),
        .value   (instr)
    );

    // Instruction decode, anything else is BYPASS
    assign sel_idcode = (instr == INSTR_IDCODE);
    assign sel_nw     = (instr == INSTR_TAPNW_SEL);

    //----------------------------------------------------------------------
    // Data registers
    //----------------------------------------------------------------------
    // Network select, survives Test-Logic-Reset
    tap_shift_reg #(
        .payload_t   (enable_mask_t),
        .RESET_VALUE ('0)
    ) nw_sel_inst (
        .tck     (tck),
        .rst_n   (rst_n),
        .capture (capture_dr && sel_nw),
        .shift   (shift_dr && sel_nw),
        .update  (update_dr && sel_nw),
        .tdi     (tdi),
        .tdo     (nw_tdo),
        .value   (enabletap)
    );

    // IDCODE shifter and bypass bit
    always_ff @(posedge tck) begin
        if (!rst_n) begin
            idcode_q <= MTAP_IDCODE;
            bypass_q <= 1'b0;
        end else begin
            if (capture_dr && sel_idcode) begin
                idcode_q <= MTAP_IDCODE;
            end else if (shift_dr && sel_idcode) begin
                idcode_q <= {tdi, idcode_q[IDCODE_WIDTH-1:1]};
            end
            // Bypass captures 0 per 1149.1
            if (capture_dr) begin
                bypass_q <= 1'b0;
            end else if (shift_dr) begin
                bypass_q <= tdi;
            end
        end
    end

    //----------------------------------------------------------------------
    // Serial output and slave tms
    //----------------------------------------------------------------------
    always_comb begin
        if (shift_ir) begin
            mtap_tdo = ir_tdo;
        end else if (sel_idcode) begin
            mtap_tdo = idcode_q[0];
        end else if (sel_nw) begin
            mtap_tdo = nw_tdo;
        end else begin
            mtap_tdo = bypass_q;
        end
    end

    assign tdo_en = shift_ir || shift_dr;

    // Disabled slaves see tms high and stay parked in reset
    assign stap_tms = (enabletap & {NUM_STAPS{tms}}) | ~enabletap;

    // Mask moves only out of an Update-DR on the select register
    assert property (@(posedge tck) disable iff (!rst_n)
        $changed(enabletap) |-> $past(update_dr && sel_nw))
        else $error("enable mask changed outside Update-DR");

endmodule

// File: hw/tap_shift_reg.sv
//----------------------------------------------------------------------
// Capture/shift/update register for JTAG scan paths.
// payload_t sets the held type; used for instructions and masks.
//----------------------------------------------------------------------

`timescale 1ns/1ps

module tap_shift_reg
    import jtag_pkg::*;
#(
    parameter type      payload_t   = ir_t,
    parameter payload_t RESET_VALUE = INSTR_IDCODE
) (
    input  logic     tck,
    input  logic     rst_n,
    input  logic     capture,
    input  logic     shift,
    input  logic     update,
    input  logic     tdi,
    output logic     tdo,
    output payload_t value
);

    localparam int WIDTH = $bits(payload_t);

    // Serial stage, LSB nearest tdo
    payload_t shift_q;

    always_ff @(posedge tck) begin
        if (!rst_n) begin
            shift_q <= RESET_VALUE;
            value   <= RESET_VALUE;
        end else begin
            // Capture reads back the held value
            if (capture) begin
                shift_q <= value;
            end else if (shift) begin
                shift_q <= payload_t'({tdi, shift_q[WIDTH-1:1]});
            end
            // Held value changes only on update
            if (update) begin
                value <= shift_q;
            end
        end
    end

    assign tdo = shift_q[0];

endmodule

// File: hw/tap_fsm.sv
//----------------------------------------------------------------------
// Sixteen-state JTAG TAP controller with decoded phase strobes.
// One instance per TAP; strobes qualify the register updates there.
//----------------------------------------------------------------------

`timescale 1ns/1ps

module tap_fsm
    import jtag_pkg::*;
(
    input  logic       tck,
    input  logic       rst_n,
    input  logic       tms,
    output tap_state_t state,
    output logic       capture_dr,
    output logic       shift_dr,
    output logic       update_dr,
    output logic       capture_ir,
    output logic       shift_ir,
    output logic       update_ir
);

    tap_state_t state_nxt;

    // Next state from tms
    always_comb begin
        unique case (state)
            ST_TLR:       state_nxt = tms ? ST_TLR       : ST_RTI;
            ST_RTI:       state_nxt = tms ? ST_SEL_DR    : ST_RTI;
            // DR column
            ST_SEL_DR:    state_nxt = tms ? ST_SEL_IR    : ST_CAP_DR;
            ST_CAP_DR:    state_nxt = tms ? ST_EXIT1_DR  : ST_SHIFT_DR;
            ST_SHIFT_DR:  state_nxt = tms ? ST_EXIT1_DR  : ST_SHIFT_DR;
            ST_EXIT1_DR:  state_nxt = tms ? ST_UPDATE_DR : ST_PAUSE_DR;
            ST_PAUSE_DR:  state_nxt = tms ? ST_EXIT2_DR  : ST_PAUSE_DR;
            ST_EXIT2_DR:  state_nxt = tms ? ST_UPDATE_DR : ST_SHIFT_DR;
            ST_UPDATE_DR: state_nxt = tms ? ST_SEL_DR    : ST_RTI;
            // IR column
            ST_SEL_IR:    state_nxt = tms ? ST_TLR       : ST_CAP_IR;
            ST_CAP_IR:    state_nxt = tms ? ST_EXIT1_IR  : ST_SHIFT_IR;
            ST_SHIFT_IR:  state_nxt = tms ? ST_EXIT1_IR  : ST_SHIFT_IR;
            ST_EXIT1_IR:  state_nxt = tms ? ST_UPDATE_IR : ST_PAUSE_IR;
            ST_PAUSE_IR:  state_nxt = tms ? ST_EXIT2_IR  : ST_PAUSE_IR;
            ST_EXIT2_IR:  state_nxt = tms ? ST_UPDATE_IR : ST_SHIFT_IR;
            ST_UPDATE_IR: state_nxt = tms ? ST_SEL_DR    : ST_RTI;
            default:      state_nxt = ST_TLR;
        endcase
    end

    always_ff @(posedge tck) begin
        if (!rst_n) begin
            state <= ST_TLR;
        end else begin
            state <= state_nxt;
        end
    end

    // Phase strobes, active for the whole state
    assign capture_dr = (state == ST_CAP_DR);
    assign shift_dr   = (state == ST_SHIFT_DR);
    assign update_dr  = (state == ST_UPDATE_DR);
    assign capture_ir = (state == ST_CAP_IR);
    assign shift_ir   = (state == ST_SHIFT_IR);
    assign update_ir  = (state == ST_UPDATE_IR);

    // Five tms-high edges reach reset from anywhere
    assert property (@(posedge tck) disable iff (!rst_n)
        tms [*5] |=> (state == ST_TLR))
        else $error("TAP not in Test-Logic-Reset after five tms-high edges");

endmodule

// File: hw/tapnw_pkg.sv
//----------------------------------------------------------------------
// TAP network configuration: number of slave TAPs, the enable mask
// and the IDCODE values of master and slaves.
// Import where the network shape or IDCODE table is needed.
//----------------------------------------------------------------------

package tapnw_pkg;

    // Slave TAPs behind the master
    localparam int NUM_STAPS = 4;

    // One enable bit per slave, bit i for slave i
    typedef logic [NUM_STAPS-1:0] enable_mask_t;

    //----------------------------------------------------------------------
    // IDCODE table
    //----------------------------------------------------------------------
    // LSB of every code is 1 as 1149.1 requires
    localparam logic [jtag_pkg::IDCODE_WIDTH-1:0] MTAP_IDCODE = 32'h1234_5679;

    // Indexed by slave number
    localparam logic [jtag_pkg::IDCODE_WIDTH-1:0] STAP_IDCODE [NUM_STAPS] = '{
        32'h1111_1111,
        32'h2222_2223,
        32'h3333_3333,
        32'h4444_4445
    };

endpackage

// File: hw/jtag_pkg.sv
//----------------------------------------------------------------------
// JTAG definitions shared by every TAP in the network: controller
// states, instruction width and opcodes, data register widths.
// Import into any module that decodes TAP state or instructions.
//----------------------------------------------------------------------

package jtag_pkg;

    //----------------------------------------------------------------------
    // TAP controller states
    //----------------------------------------------------------------------
    // Encoding follows the IEEE 1149.1 state assignment
    typedef enum logic [3:0] {
        ST_TLR       = 4'hF,
        ST_RTI       = 4'hC,
        ST_SEL_DR    = 4'h7,
        ST_CAP_DR    = 4'h6,
        ST_SHIFT_DR  = 4'h2,
        ST_EXIT1_DR  = 4'h1,
        ST_PAUSE_DR  = 4'h3,
        ST_EXIT2_DR  = 4'h0,
        ST_UPDATE_DR = 4'h5,
        ST_SEL_IR    = 4'h4,
        ST_CAP_IR    = 4'hE,
        ST_SHIFT_IR  = 4'hA,
        ST_EXIT1_IR  = 4'h9,
        ST_PAUSE_IR  = 4'hB,
        ST_EXIT2_IR  = 4'h8,
        ST_UPDATE_IR = 4'hD
    } tap_state_t;

    //----------------------------------------------------------------------
    // Instruction register
    //----------------------------------------------------------------------
    localparam int IR_WIDTH = 4;

    typedef logic [IR_WIDTH-1:0] ir_t;

    // Default after reset and in Test-Logic-Reset
    localparam ir_t INSTR_IDCODE    = 4'h2;
    // Network select, master only
    localparam ir_t INSTR_TAPNW_SEL = 4'h4;
    // Unknown opcodes decode as this too
    localparam ir_t INSTR_BYPASS    = 4'hF;

    // Data register widths
    localparam int IDCODE_WIDTH = 32;

endpackage
